//--- mc_consts.svh
`ifndef MC_CONSTS_SVH
`define MC_CONSTS_SVH

// eva and data word width
`define MC_DATA_W 32
// endpoint physical address, word granular
`define MC_ADDR_W 20

// global mesh coordinates
`define MC_X_CORD_W 7
`define MC_Y_CORD_W 7
// pod coordinates, upper part of the global ones
`define MC_POD_X_W 3
`define MC_POD_Y_W 4

// tiles per pod and the matching subcoordinate widths
`define MC_TILES_X 16
`define MC_TILES_Y 8
`define MC_X_SUB_W $clog2(`MC_TILES_X)
`define MC_Y_SUB_W $clog2(`MC_TILES_Y)

// vcache geometry
`define MC_VC_BLOCK_WORDS 8
`define MC_VC_SIZE_WORDS 1024
`define MC_VC_SETS 64

// tx queue slots and network credits
`define MC_Q_DEPTH 4
`define MC_NET_CREDITS 4

`endif

//--- mc_addr_pkg.sv
`default_nettype none

`include "mc_consts.svh"

package mc_addr_pkg;

  // remote field codes at the top of the eva
  localparam logic [1:0] mc_global_remote = 2'b01;
  localparam logic [2:0] mc_tile_group_remote = 3'b001;

  // global eva, x/y and word address given directly
  typedef struct packed {
    logic [1:0]  remote;
    logic [5:0]  y_cord;
    logic [5:0]  x_cord;
    logic [17:0] addr;
  } mc_global_addr_s;

  // tile-group eva, offsets relative to the group origin
  typedef struct packed {
    logic [2:0]  remote;
    logic [5:0]  y_cord;
    logic [5:0]  x_cord;
    logic [16:0] addr;
  } mc_tile_group_addr_s;

  // network physical address
  typedef struct packed {
    logic [`MC_X_CORD_W-1:0] x_cord;
    logic [`MC_Y_CORD_W-1:0] y_cord;
    logic [`MC_ADDR_W-1:0]   epa;
  } mc_npa_s;

endpackage

`default_nettype wire

//--- mc_net_pkg.sv
`default_nettype none

`include "mc_consts.svh"

package mc_net_pkg;

  import mc_addr_pkg::*;

  // request opcodes, carried unchanged to the mesh
  typedef enum logic [1:0] {
    e_op_load   = 2'd0,
    e_op_store  = 2'd1,
    e_op_amoadd = 2'd2
  } mc_op_e;

  // one translated request on its way out
  typedef struct packed {
    mc_op_e                op;
    mc_npa_s               npa;
    // store data or amo operand
    logic [`MC_DATA_W-1:0] data;
  } mc_packet_s;

endpackage

`default_nettype wire

//--- mc_pkt_if.sv
`default_nettype none

interface mc_pkt_if
  import mc_net_pkg::*;
  ();

  // one-cycle push of a translated packet
  logic       pkt_v;
  mc_packet_s pkt;
  // one-cycle pulse per queue entry popped
  logic       slot_credit;

  modport xlate (output pkt_v, output pkt, input slot_credit);

  modport tx (input pkt_v, input pkt, output slot_credit);

endinterface

`default_nettype wire

//--- mc_dram_hash.sv
`default_nettype none

`include "mc_consts.svh"

module mc_dram_hash #(
  // cache-block number width
  parameter int in_width_p = 26,
  // one vcache row above and one below the pod
  parameter int banks_p = 2 * `MC_TILES_X,
  parameter int index_width_p = $clog2(`MC_VC_SETS)
) (
  input  logic [in_width_p-1:0]       hash_in_i,
  // {bot_not_top, x}
  output logic [$clog2(banks_p)-1:0]  bank_o,
  // set index inside the chosen vcache
  output logic [index_width_p-1:0]    index_o
);

  localparam int lg_banks_lp = $clog2(banks_p);

  logic [in_width_p-1:0] bank_full;
  logic [in_width_p-1:0] index_full;

  // consecutive blocks go to consecutive banks
  assign bank_full = hash_in_i % in_width_p'(banks_p);
  // remaining bits select the set
  assign index_full = hash_in_i / in_width_p'(banks_p);

  // power-of-two bank count, so both reduce to slices
  assign bank_o = bank_full[lg_banks_lp-1:0];
  assign index_o = index_full[index_width_p-1:0];

endmodule

`default_nettype wire

//--- mc_eva_to_npa.sv
`default_nettype none

`include "mc_consts.svh"

module mc_eva_to_npa
  import mc_addr_pkg::*;
(
  // byte address from the core
  input  logic [`MC_DATA_W-1:0]  eva_i,
  // tile-group origin inside the pod
  input  logic [`MC_X_SUB_W-1:0] tgo_x_i,
  input  logic [`MC_Y_SUB_W-1:0] tgo_y_i,
  input  logic [`MC_POD_X_W-1:0] pod_x_i,
  input  logic [`MC_POD_Y_W-1:0] pod_y_i,
  // striping across vcaches on, else linear
  input  logic                   dram_enable_i,
  output mc_npa_s                npa_o,
  output logic                   is_invalid_addr_o
);

  localparam int x_sub_w_lp = `MC_X_SUB_W;
  localparam int y_sub_w_lp = `MC_Y_SUB_W;
  localparam int word_off_w_lp = $clog2(`MC_VC_BLOCK_WORDS);
  localparam int lg_vc_size_lp = $clog2(`MC_VC_SIZE_WORDS);
  // byte offset and dram bit stripped off
  localparam int hash_in_w_lp = `MC_DATA_W - 1 - 2 - word_off_w_lp;
  localparam int index_w_lp = $clog2(`MC_VC_SETS);

  mc_global_addr_s               global_addr;
  mc_tile_group_addr_s           tile_group_addr;
  logic                          is_dram;
  logic                          is_global;
  logic                          is_tile_group;
  logic [hash_in_w_lp-1:0]       hash_in;
  logic [x_sub_w_lp:0]           hash_bank;
  logic [index_w_lp-1:0]         hash_index;
  logic [`MC_Y_CORD_W-1:0]       y_bot;
  logic [`MC_Y_CORD_W-1:0]       y_top;
  logic                          linear_bot;

  // same eva seen through both layouts
  assign global_addr = eva_i;
  assign tile_group_addr = eva_i;

  assign is_dram = eva_i[31];
  assign is_global = global_addr.remote == mc_global_remote;
  assign is_tile_group = tile_group_addr.remote == mc_tile_group_remote;
  assign is_invalid_addr_o = ~(is_dram | is_global | is_tile_group);

  // block number of the dram address
  assign hash_in = eva_i[2+word_off_w_lp +: hash_in_w_lp];

  mc_dram_hash #(
    .in_width_p   (hash_in_w_lp),
    .banks_p      (2 * `MC_TILES_X),
    .index_width_p(index_w_lp)
  ) u_hash (
    .hash_in_i(hash_in),
    .bank_o   (hash_bank),
    .index_o  (hash_index)
  );

  // vcache rows: first row of the pod below, last row of the pod above
  assign y_bot = {`MC_POD_Y_W'(pod_y_i + 1'b1), {y_sub_w_lp{1'b0}}};
  assign y_top = {`MC_POD_Y_W'(pod_y_i - 1'b1), {y_sub_w_lp{1'b1}}};

  // linear mode, bit above the x field picks the row
  assign linear_bot = eva_i[2+lg_vc_size_lp+x_sub_w_lp];

  always_comb begin
    npa_o = '0;
    if (is_dram) begin
      if (dram_enable_i) begin
        // striped at cache-block granularity
        npa_o.y_cord = hash_bank[x_sub_w_lp] ? y_bot : y_top;
        npa_o.x_cord = {pod_x_i, hash_bank[x_sub_w_lp-1:0]};
        npa_o.epa = `MC_ADDR_W'({hash_index, eva_i[2 +: word_off_w_lp]});
      end else begin
        // vcaches as plain block memory
        npa_o.y_cord = linear_bot ? y_bot : y_top;
        npa_o.x_cord = {pod_x_i, eva_i[2+lg_vc_size_lp +: x_sub_w_lp]};
        npa_o.epa = `MC_ADDR_W'(eva_i[2 +: lg_vc_size_lp]);
      end
    end else if (is_global) begin
      // coordinates encoded directly
      npa_o.y_cord = `MC_Y_CORD_W'(global_addr.y_cord);
      npa_o.x_cord = `MC_X_CORD_W'(global_addr.x_cord);
      npa_o.epa = `MC_ADDR_W'(global_addr.addr);
    end else if (is_tile_group) begin
      // offsets wrap inside the pod
      npa_o.y_cord = {pod_y_i, y_sub_w_lp'(tile_group_addr.y_cord + tgo_y_i)};
      npa_o.x_cord = {pod_x_i, x_sub_w_lp'(tile_group_addr.x_cord + tgo_x_i)};
      npa_o.epa = `MC_ADDR_W'(tile_group_addr.addr);
    end
  end

endmodule

`default_nettype wire

//--- mc_req_xlate.sv
`default_nettype none

`include "mc_consts.svh"

module mc_req_xlate
  import mc_addr_pkg::*, mc_net_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  // core request
  input  logic                   req_v_i,
  input  mc_op_e                 req_op_i,
  input  logic [`MC_DATA_W-1:0]  req_eva_i,
  input  logic [`MC_DATA_W-1:0]  req_data_i,
  // endpoint configuration
  input  logic [`MC_X_SUB_W-1:0] tgo_x_i,
  input  logic [`MC_Y_SUB_W-1:0] tgo_y_i,
  input  logic [`MC_POD_X_W-1:0] pod_x_i,
  input  logic [`MC_POD_Y_W-1:0] pod_y_i,
  input  logic                   dram_enable_i,
  output logic                   req_ready_o,
  output logic                   err_o,
  mc_pkt_if.xlate                pkt_if
);

  localparam int cnt_w_lp = $clog2(`MC_Q_DEPTH + 1);

  mc_npa_s               npa;
  logic                  invalid;
  logic                  accept;
  logic [cnt_w_lp-1:0]   credit_cnt;
  logic                  pkt_v_q;
  logic                  err_q;
  mc_packet_s            pkt_q;

  mc_eva_to_npa u_eva_to_npa (
    .eva_i            (req_eva_i),
    .tgo_x_i          (tgo_x_i),
    .tgo_y_i          (tgo_y_i),
    .pod_x_i          (pod_x_i),
    .pod_y_i          (pod_y_i),
    .dram_enable_i    (dram_enable_i),
    .npa_o            (npa),
    .is_invalid_addr_o(invalid)
  );

  // one free queue slot is enough to take a request
  assign req_ready_o = credit_cnt != '0;
  assign accept = req_v_i & req_ready_o;

  // spend on accept, refund on drop or on pop downstream
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      credit_cnt <= cnt_w_lp'(`MC_Q_DEPTH);
    end else begin
      credit_cnt <= credit_cnt - cnt_w_lp'(accept) + cnt_w_lp'(err_q)
                    + cnt_w_lp'(pkt_if.slot_credit);
    end
  end

  // exactly one of these per accepted request
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pkt_v_q <= 1'b0;
      err_q <= 1'b0;
    end else begin
      pkt_v_q <= accept & ~invalid;
      err_q <= accept & invalid;
    end
  end

  // payload held with the pulse
  always_ff @(posedge clk_i) begin
    if (accept) begin
      pkt_q.op <= req_op_i;
      pkt_q.npa <= npa;
      pkt_q.data <= req_data_i;
    end
  end

  assign pkt_if.pkt_v = pkt_v_q;
  assign pkt_if.pkt = pkt_q;
  assign err_o = err_q;

endmodule

`default_nettype wire

//--- mc_net_tx.sv
`default_nettype none

`include "mc_consts.svh"

module mc_net_tx
  import mc_net_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  mc_pkt_if.tx       pkt_if,
  // one pulse per packet the mesh has consumed
  input  logic       credit_return_i,
  output logic       pkt_v_o,
  output mc_packet_s pkt_o
);

  localparam int ptr_w_lp = $clog2(`MC_Q_DEPTH);
  localparam int q_cnt_w_lp = $clog2(`MC_Q_DEPTH + 1);
  localparam int net_cnt_w_lp = $clog2(`MC_NET_CREDITS + 1);

  mc_packet_s              queue_mem [`MC_Q_DEPTH];
  logic [ptr_w_lp-1:0]     wr_ptr;
  logic [ptr_w_lp-1:0]     rd_ptr;
  logic [q_cnt_w_lp-1:0]   q_cnt;
  logic [net_cnt_w_lp-1:0] net_credit_cnt;
  logic                    push;
  logic                    pop;

  // overflow is ruled out by the slot credits upstream
  assign push = pkt_if.pkt_v;
  // send only with a queued packet and a network credit
  assign pop = (q_cnt != '0) && (net_credit_cnt != '0);

  // freed slot goes straight back to the translator
  assign pkt_if.slot_credit = pop;

  always_ff @(posedge clk_i) begin
    if (push) begin
      queue_mem[wr_ptr] <= pkt_if.pkt;
    end
  end

  // circular pointers and fill level
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      q_cnt <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == ptr_w_lp'(`MC_Q_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == ptr_w_lp'(`MC_Q_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      q_cnt <= q_cnt + q_cnt_w_lp'(push) - q_cnt_w_lp'(pop);
    end
  end

  // a return may land on the same edge as a send
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      net_credit_cnt <= net_cnt_w_lp'(`MC_NET_CREDITS);
    end else begin
      net_credit_cnt <= net_credit_cnt - net_cnt_w_lp'(pop)
                        + net_cnt_w_lp'(credit_return_i);
    end
  end

  // registered link outputs
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pkt_v_o <= 1'b0;
    end else begin
      pkt_v_o <= pop;
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop) begin
      pkt_o <= queue_mem[rd_ptr];
    end
  end

endmodule

`default_nettype wire

//--- mc_endpoint_top.sv
`default_nettype none

`include "mc_consts.svh"

module mc_endpoint_top
  import mc_net_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  // core request side
  input  logic                    req_v_i,
  input  mc_op_e                  req_op_i,
  input  logic [`MC_DATA_W-1:0]   req_eva_i,
  input  logic [`MC_DATA_W-1:0]   req_data_i,
  // endpoint configuration
  input  logic [`MC_X_SUB_W-1:0]  tgo_x_i,
  input  logic [`MC_Y_SUB_W-1:0]  tgo_y_i,
  input  logic [`MC_POD_X_W-1:0]  pod_x_i,
  input  logic [`MC_POD_Y_W-1:0]  pod_y_i,
  input  logic                    dram_enable_i,
  // mesh side
  input  logic                    credit_return_i,
  output logic                    req_ready_o,
  output logic                    err_o,
  output logic                    pkt_v_o,
  output mc_op_e                  pkt_op_o,
  output logic [`MC_X_CORD_W-1:0] pkt_x_o,
  output logic [`MC_Y_CORD_W-1:0] pkt_y_o,
  output logic [`MC_ADDR_W-1:0]   pkt_epa_o,
  output logic [`MC_DATA_W-1:0]   pkt_data_o
);

  mc_packet_s pkt;

  // translator to transmitter link
  mc_pkt_if pkt_if ();

  mc_req_xlate u_xlate (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .req_v_i      (req_v_i),
    .req_op_i     (req_op_i),
    .req_eva_i    (req_eva_i),
    .req_data_i   (req_data_i),
    .tgo_x_i      (tgo_x_i),
    .tgo_y_i      (tgo_y_i),
    .pod_x_i      (pod_x_i),
    .pod_y_i      (pod_y_i),
    .dram_enable_i(dram_enable_i),
    .req_ready_o  (req_ready_o),
    .err_o        (err_o),
    .pkt_if       (pkt_if.xlate)
  );

  mc_net_tx u_tx (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .pkt_if         (pkt_if.tx),
    .credit_return_i(credit_return_i),
    .pkt_v_o        (pkt_v_o),
    .pkt_o          (pkt)
  );

  // flatten the packet for the mesh link
  assign pkt_op_o = pkt.op;
  assign pkt_x_o = pkt.npa.x_cord;
  assign pkt_y_o = pkt.npa.y_cord;
  assign pkt_epa_o = pkt.npa.epa;
  assign pkt_data_o = pkt.data;

endmodule

`default_nettype wire

//--- mc_props.sv
`default_nettype none

`include "mc_consts.svh"

module mc_props (
  input logic                                 clk_i,
  input logic                                 rst_n_i,
  input logic                                 req_v_i,
  input logic [`MC_DATA_W-1:0]                req_eva_i,
  input logic                                 req_ready_i,
  input logic                                 err_i,
  input logic                                 pkt_v_i,
  // translator packet pulse, same cycle as err for one request
  input logic                                 xlate_pkt_v_i,
  input logic [$clog2(`MC_NET_CREDITS+1)-1:0] net_credit_cnt_i
);

  // credit counter bounded by the link depth
  credit_bound_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    net_credit_cnt_i <= `MC_NET_CREDITS)
    else $error("network credit count above its maximum");

  // departure needs a credit in the cycle it was popped
  no_send_without_credit_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pkt_v_i |-> $past(net_credit_cnt_i) != '0)
    else $error("packet left with no network credit");

  // all slot credits available out of reset
  ready_after_reset_a: assert property (@(posedge clk_i)
    $rose(rst_n_i) |-> req_ready_i)
    else $error("req_ready_o low after reset");

  // one outcome per accepted request, the error only for an eva of no mapping
  err_excludes_pkt_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $past(req_v_i && req_ready_i) |->
      (err_i != xlate_pkt_v_i) && (err_i == ($past(req_eva_i[31:29]) == 3'b000)))
    else $error("error pulse and translated packet disagree with the request address");

endmodule

bind mc_endpoint_top mc_props u_props (
  .clk_i           (clk_i),
  .rst_n_i         (rst_n_i),
  .req_v_i         (req_v_i),
  .req_eva_i       (req_eva_i),
  .req_ready_i     (req_ready_o),
  .err_i           (err_o),
  .pkt_v_i         (pkt_v_o),
  .xlate_pkt_v_i   (u_xlate.pkt_v_q),
  .net_credit_cnt_i(u_tx.net_credit_cnt)
);

`default_nettype wire

//--- mc_tb.sv
`default_nettype none

`include "mc_consts.svh"

module mc_tb
  import mc_addr_pkg::*, mc_net_pkg::*;
();

  // reference outcome, invalid means dropped with err_o
  typedef struct packed {
    logic    invalid;
    mc_npa_s npa;
  } ref_result_s;

  localparam int wait_limit = 1000;

  logic                    clk_i;
  logic                    rst_n_i;
  logic                    req_v_i;
  mc_op_e                  req_op_i;
  logic [`MC_DATA_W-1:0]   req_eva_i;
  logic [`MC_DATA_W-1:0]   req_data_i;
  logic [`MC_X_SUB_W-1:0]  tgo_x_i;
  logic [`MC_Y_SUB_W-1:0]  tgo_y_i;
  logic [`MC_POD_X_W-1:0]  pod_x_i;
  logic [`MC_POD_Y_W-1:0]  pod_y_i;
  logic                    dram_enable_i;
  logic                    credit_return_i;
  logic                    req_ready_o;
  logic                    err_o;
  logic                    pkt_v_o;
  mc_op_e                  pkt_op_o;
  logic [`MC_X_CORD_W-1:0] pkt_x_o;
  logic [`MC_Y_CORD_W-1:0] pkt_y_o;
  logic [`MC_ADDR_W-1:0]   pkt_epa_o;
  logic [`MC_DATA_W-1:0]   pkt_data_o;

  int          seed;
  int          net_seed;
  mc_packet_s  exp_q[$];
  mc_packet_s  exp_pkt;
  mc_npa_s     got_npa;
  // network model state
  int          due_q[$];
  int          outstanding;
  int          cycle;
  int          net_due;
  logic [31:0] net_rnd;
  logic        hold_credits;

  mc_endpoint_top uut (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .req_v_i(req_v_i), .req_op_i(req_op_i),
    .req_eva_i(req_eva_i), .req_data_i(req_data_i), .tgo_x_i(tgo_x_i),
    .tgo_y_i(tgo_y_i), .pod_x_i(pod_x_i), .pod_y_i(pod_y_i),
    .dram_enable_i(dram_enable_i), .credit_return_i(credit_return_i),
    .req_ready_o(req_ready_o), .err_o(err_o), .pkt_v_o(pkt_v_o),
    .pkt_op_o(pkt_op_o), .pkt_x_o(pkt_x_o), .pkt_y_o(pkt_y_o),
    .pkt_epa_o(pkt_epa_o), .pkt_data_o(pkt_data_o)
  );

  always #2 clk_i = ~clk_i;

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("Verification failed");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic check_npa(input mc_npa_s exp, input mc_npa_s got);
    if (got !== exp) begin
      stop_with_failure($sformatf("** Error: {pkt_x_o,pkt_y_o,pkt_epa_o} expected 0x%h, got 0x%h",
                                  exp, got));
    end
  endtask

  task automatic check_op(input mc_op_e exp, input mc_op_e got);
    if (got !== exp) begin
      stop_with_failure($sformatf("** Error: pkt_op_o expected 0x%h, got 0x%h", exp, got));
    end
  endtask

  task automatic check_data(input logic [`MC_DATA_W-1:0] exp, input logic [`MC_DATA_W-1:0] got);
    if (got !== exp) begin
      stop_with_failure($sformatf("** Error: pkt_data_o expected 0x%h, got 0x%h", exp, got));
    end
  endtask

  task automatic check_err(input logic exp, input logic got);
    if (got !== exp) begin
      stop_with_failure($sformatf("** Error: err_o expected 0x%h, got 0x%h", exp, got));
    end
  endtask

  // expected translation from the address map rules
  function automatic ref_result_s mc_ref_xlate(input logic [31:0] eva,
                                               input logic [`MC_X_SUB_W-1:0] tgo_x,
                                               input logic [`MC_Y_SUB_W-1:0] tgo_y,
                                               input logic [`MC_POD_X_W-1:0] pod_x,
                                               input logic [`MC_POD_Y_W-1:0] pod_y,
                                               input logic dram_on);
    ref_result_s res;
    logic        row_bot;
    logic [3:0]  x_sub;
    logic [2:0]  y_sub;
    res = '0;
    if (eva[31]) begin
      if (dram_on) begin
        // block number starts at bit 5, bank is its low 5 bits
        row_bot = eva[9];
        x_sub = eva[8:5];
        // set index above the bank, then word in block
        res.npa.epa = {11'd0, eva[15:10], eva[4:2]};
      end else begin
        row_bot = eva[16];
        x_sub = eva[15:12];
        res.npa.epa = {10'd0, eva[11:2]};
      end
      res.npa.x_cord = {pod_x, x_sub};
      res.npa.y_cord = row_bot ? {pod_y + 4'd1, 3'b000} : {pod_y - 4'd1, 3'b111};
    end else if (eva[31:30] == 2'b01) begin
      res.npa.x_cord = {1'b0, eva[23:18]};
      res.npa.y_cord = {1'b0, eva[29:24]};
      res.npa.epa = {2'b00, eva[17:0]};
    end else if (eva[31:29] == 3'b001) begin
      // offsets wrap within the pod
      x_sub = eva[20:17] + tgo_x;
      y_sub = eva[25:23] + tgo_y;
      res.npa.x_cord = {pod_x, x_sub};
      res.npa.y_cord = {pod_y, y_sub};
      res.npa.epa = {3'b000, eva[16:0]};
    end else begin
      res.invalid = 1'b1;
    end
    return res;
  endfunction

  function automatic logic [31:0] rand_word();
    rand_word = $random(seed);
  endfunction

  function automatic mc_op_e rand_op();
    logic [31:0] r;
    r = rand_word();
    case (r[1:0])
      2'd0: rand_op = e_op_load;
      2'd1: rand_op = e_op_store;
      default: rand_op = e_op_amoadd;
    endcase
  endfunction

  task automatic randomize_config(input logic dram_on);
    logic [31:0] r;
    r = rand_word();
    pod_x_i = r[2:0];
    pod_y_i = r[6:3];
    tgo_x_i = r[10:7];
    tgo_y_i = r[13:11];
    dram_enable_i = dram_on;
  endtask

  // called at a falling edge, returns at the falling edge after acceptance
  task automatic send_req(input logic [31:0] eva);
    ref_result_s res;
    mc_packet_s  pkt;
    mc_op_e      op;
    logic [31:0] data;
    int          waits;
    op = rand_op();
    data = rand_word();
    req_v_i = 1'b1;
    req_op_i = op;
    req_eva_i = eva;
    req_data_i = data;
    waits = 0;
    while (!req_ready_o && waits < wait_limit) begin
      @(negedge clk_i);
      waits++;
    end
    if (!req_ready_o) begin
      stop_with_failure("timeout: req_ready_o stayed low while a request was waiting");
    end else begin
      res = mc_ref_xlate(eva, tgo_x_i, tgo_y_i, pod_x_i, pod_y_i, dram_enable_i);
      if (!res.invalid) begin
        pkt.op = op;
        pkt.npa = res.npa;
        pkt.data = data;
        exp_q.push_back(pkt);
      end
      @(negedge clk_i);
      req_v_i = 1'b0;
      // error pulse one cycle after the accepting edge
      check_err(res.invalid, err_o);
    end
  endtask

  task automatic run_dram_phase(input logic dram_on, input int n);
    logic [31:0] r;
    for (int i = 0; i < n; i++) begin
      randomize_config(dram_on);
      r = rand_word();
      // both vcache rows in linear mode
      if (!dram_on) r[16] = i[0];
      send_req({1'b1, r[30:0]});
    end
  endtask

  task automatic run_remote_phase(input int n);
    logic [31:0] r;
    for (int i = 0; i < n; i++) begin
      r = rand_word();
      randomize_config(r[31]);
      if (i[0]) send_req({2'b01, r[29:0]});
      else send_req({3'b001, r[28:0]});
    end
  endtask

  // every third request carries a prefix of no mapping
  task automatic run_invalid_phase(input int n);
    logic [31:0] r;
    for (int i = 0; i < n; i++) begin
      randomize_config(1'b1);
      r = rand_word();
      if (i % 3 == 0) send_req({3'b000, r[28:0]});
      else if (i % 3 == 1) send_req({1'b1, r[30:0]});
      else send_req({2'b01, r[29:0]});
    end
  endtask

  task automatic wait_drain();
    int waits;
    waits = 0;
    while ((exp_q.size() != 0 || outstanding != 0) && waits < wait_limit) begin
      @(posedge clk_i);
      waits++;
    end
    if (exp_q.size() != 0 || outstanding != 0) begin
      stop_with_failure("timeout: packets or network credits still outstanding");
    end
  endtask

  task automatic wait_ready_low();
    int waits;
    waits = 0;
    while (req_ready_o && waits < wait_limit) begin
      @(negedge clk_i);
      waits++;
    end
    if (req_ready_o) begin
      stop_with_failure("timeout: req_ready_o stayed high with the queue full");
    end
  endtask

  task automatic wait_credits_used();
    int waits;
    waits = 0;
    while (outstanding != `MC_NET_CREDITS && waits < wait_limit) begin
      @(posedge clk_i);
      waits++;
    end
    if (outstanding != `MC_NET_CREDITS) begin
      stop_with_failure("timeout: network credits never all in use while withheld");
    end
  endtask

  task automatic run_backpressure_phase();
    logic [31:0] r;
    wait_drain();
    hold_credits = 1'b1;
    @(negedge clk_i);
    // four go out on credits, four fill the queue
    for (int i = 0; i < 2 * `MC_Q_DEPTH; i++) begin
      randomize_config(1'b0);
      r = rand_word();
      send_req({2'b01, r[29:0]});
    end
    wait_ready_low();
    wait_credits_used();
    hold_credits = 1'b0;
    @(negedge clk_i);
    for (int i = 0; i < `MC_Q_DEPTH; i++) begin
      randomize_config(1'b1);
      r = rand_word();
      send_req({1'b1, r[30:0]});
    end
  endtask

  // network model, one credit back per packet after a random delay
  always @(negedge clk_i) begin
    cycle = cycle + 1;
    credit_return_i = 1'b0;
    if (rst_n_i) begin
      if (pkt_v_o) begin
        outstanding = outstanding + 1;
        net_rnd = $random(net_seed);
        net_due = cycle + int'(net_rnd[2:0]);
        // occasional long stall
        if (net_rnd[7:4] == 4'd0) net_due = net_due + 24;
        if (due_q.size() != 0 && net_due < due_q[$]) net_due = due_q[$];
        due_q.push_back(net_due);
      end
      if (outstanding > `MC_NET_CREDITS) begin
        stop_with_failure("more packets outstanding on the mesh than network credits");
      end else if (!hold_credits && due_q.size() != 0 && due_q[0] <= cycle) begin
        void'(due_q.pop_front());
        credit_return_i = 1'b1;
        outstanding = outstanding - 1;
      end
    end
  end

  // compare each departing packet with the oldest expected one
  always @(negedge clk_i) begin
    if (rst_n_i && pkt_v_o) begin
      if (exp_q.size() == 0) begin
        stop_with_failure("packet sent on the mesh with no request expected");
      end else begin
        exp_pkt = exp_q.pop_front();
        got_npa.x_cord = pkt_x_o;
        got_npa.y_cord = pkt_y_o;
        got_npa.epa = pkt_epa_o;
        check_op(exp_pkt.op, pkt_op_o);
        check_npa(exp_pkt.npa, got_npa);
        check_data(exp_pkt.data, pkt_data_o);
      end
    end
  end

  initial begin
    seed = 32'h6867;
    net_seed = 32'h6867;
    clk_i = 1'b0;
    rst_n_i = 1'b0;
    req_v_i = 1'b0;
    req_op_i = e_op_load;
    req_eva_i = '0;
    req_data_i = '0;
    tgo_x_i = '0;
    tgo_y_i = '0;
    pod_x_i = '0;
    pod_y_i = '0;
    dram_enable_i = 1'b0;
    credit_return_i = 1'b0;
    hold_credits = 1'b0;
    outstanding = 0;
    cycle = 0;
    repeat (16) @(negedge clk_i);
    rst_n_i = 1'b1;
    run_dram_phase(1'b1, 40);
    run_dram_phase(1'b0, 40);
    run_remote_phase(40);
    run_invalid_phase(30);
    run_backpressure_phase();
    wait_drain();
    // every slot credit is back once the queue has drained
    @(negedge clk_i);
    if (req_ready_o !== 1'b1) begin
      stop_with_failure($sformatf("** Error: req_ready_o expected 0x1, got 0x%h", req_ready_o));
    end else begin
      $display("Verification passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- tb.f
+incdir+.
mc_addr_pkg.sv
mc_net_pkg.sv
mc_pkt_if.sv
mc_dram_hash.sv
mc_eva_to_npa.sv
mc_req_xlate.sv
mc_net_tx.sv
mc_endpoint_top.sv
mc_props.sv
mc_tb.sv

//--- run.sh
#!/bin/sh
# build and run the endpoint testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module mc_tb -o mc_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/mc_sim
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit 1
fi

exit 0
